// File: dv/aligner_tmr_sva.sv
/*
 * Concurrent checks bound into the TMR aligner top level.
 */
`timescale 1ns/1ps

module aligner_tmr_sva (
        input logic                 clk,
        input logic                 rst_n_i,
        input logic [2:0]           is_broken_o,
        input logic                 err_detected_o,
        input logic                 err_corrected_o,
        input aligner_pkg::al_out_t al_out_o
);
        // Broken flags are sticky outside reset
        assert property (@(posedge clk) rst_n_i && $past(rst_n_i) |->
                         (($past(is_broken_o) & ~is_broken_o) == 3'b000))
                else $error("is_broken bit fell while out of reset");

        assert property (@(posedge clk) disable iff (!rst_n_i) err_corrected_o |-> err_detected_o)
                else $error("err_corrected high without err_detected");

        assert property (@(posedge clk) $rose(rst_n_i) |-> !al_out_o.instr_valid)
                else $error("instr_valid high in first cycle after reset");

endmodule

// File: dv/tb_aligner_tmr.sv
/*
 * Testbench top for the TMR fetch aligner.
 * The program image is 256 halfwords and addresses wrap every 512 bytes.
 * The fetch model follows the PC and state of copy 0.
 */
`timescale 1ns/1ps

module tb_aligner_tmr;
        import aligner_pkg::*;

        logic        clk;
        logic        por_n;
        logic        soft_rst_n = 1'b1;
        logic        rst_n;
        al_in_t      al_in [N_REPLICA];
        logic [2:0]  set_broken = '0;
        al_out_t     al_out;
        logic [2:0]  is_broken;
        logic        err_det;
        logic        err_corr;
        half_t       image [256];
        logic [16:0] lfsr = 17'd86638;
        logic [2:0]  corrupt_req = '0;
        logic [2:0]  corrupt = '0;
        logic        bp_en = 1'b0;
        logic        prev_rst = 1'b1;
        int          errors;
        int          taken;
        int          timeouts = 0;
        int          err_mark;
        int          tmo_mark;
        int          cyc;

        assign rst_n = por_n & soft_rst_n;

        tb_clk_gen i_clk_gen (.clk_o(clk), .rst_n_o(por_n));

        aligner_tmr i_dut (
                .clk             (clk),
                .rst_n_i         (rst_n),
                .al_in_i         (al_in),
                .set_broken_i    (set_broken),
                .al_out_o        (al_out),
                .is_broken_o     (is_broken),
                .err_detected_o  (err_det),
                .err_corrected_o (err_corr)
        );

        tb_checker i_checker (
                .clk (clk), .rst_n_i (rst_n), .in0_i (al_in[0]), .set_broken_i (set_broken),
                .corrupt_i (corrupt), .out_i (al_out), .is_broken_i (is_broken),
                .det_i (err_det), .corr_i (err_corr), .image_i (image),
                .errors_o (errors), .taken_o (taken)
        );

        bind aligner_tmr aligner_tmr_sva i_sva (
                .clk (clk), .rst_n_i (rst_n_i), .is_broken_o (is_broken_o),
                .err_detected_o (err_detected_o), .err_corrected_o (err_corrected_o),
                .al_out_o (al_out_o)
        );

        // Fibonacci LFSR, taps 17 and 14
        function automatic logic [16:0] lfsr_step(input logic [16:0] s);
                return {s[15:0], s[16] ^ s[13]};
        endfunction

        task automatic run_cycle(input logic br, input logic [31:0] addr,
                                 input logic [2:0] setb, input logic rst_req);
                al_in_t      base;
                al_state_e   st;
                logic [31:0] pc;
                logic [31:0] waddr;
                logic        b0;
                logic        b1;
                logic        rst_now;
                @(posedge clk);
                #2;
                soft_rst_n = ~rst_req;
                rst_now    = por_n & soft_rst_n;
                st    = i_dut.g_replica[0].i_aligner.state_q;
                pc    = i_dut.g_replica[0].i_aligner.pc_q;
                waddr = (st == MISALIGNED32) ? pc + 32'd2 : pc;
                base.fetch_rdata.word = {image[{waddr[8:2], 1'b1}], image[{waddr[8:2], 1'b0}]};
                base.fetch_valid = (st != MISALIGNED16) && rst_now && !prev_rst;
                if (!base.fetch_valid) begin
                        base.fetch_rdata.word = '0;
                end
                lfsr = lfsr_step(lfsr);
                b0   = lfsr[0];
                lfsr = lfsr_step(lfsr);
                b1   = lfsr[0];
                base.if_valid    = bp_en ? (b0 | b1) : 1'b1;
                base.branch      = br;
                base.branch_addr = addr;
                // Corruption begins outside MISALIGNED16 so the copy differs at once
                if (!rst_now) begin
                        corrupt = '0;
                end else if (al_out.ready) begin
                        corrupt = corrupt | corrupt_req;
                end
                for (int k = 0; k < N_REPLICA; k++) begin
                        al_in[k] = base;
                        if (corrupt[k]) begin
                                al_in[k].fetch_rdata.word = base.fetch_rdata.word ^ 32'h0010_0010;
                        end
                end
                set_broken = setb;
                prev_rst   = !rst_now;
        endtask

        task automatic apply_reset();
                corrupt_req = '0;
                repeat (10) run_cycle(1'b0, '0, '0, 1'b1);
                run_cycle(1'b0, '0, '0, 1'b0);
        endtask

        task automatic run_instrs(input int n, input int tmo);
                int start;
                int c;
                start = taken;
                c     = 0;
                while ((taken - start) < n && c < tmo) begin
                        run_cycle(1'b0, '0, '0, 1'b0);
                        c++;
                end
                if ((taken - start) < n) begin
                        $display("Timeout: only %0d of %0d instructions were taken", taken - start, n);
                        timeouts++;
                end
        endtask

        task automatic wait_broken(input int k, input int tmo);
                int c;
                c = 0;
                while (!is_broken[k] && c < tmo) begin
                        run_cycle(1'b0, '0, '0, 1'b0);
                        c++;
                end
                if (!is_broken[k]) begin
                        $display("Timeout: copy %0d was never marked broken", k);
                        timeouts++;
                end
        endtask

        task automatic end_test(input string name);
                $display("test %s: %0d errors, %0d timeouts", name, errors - err_mark,
                         timeouts - tmo_mark);
                err_mark = errors;
                tmo_mark = timeouts;
        endtask

        initial begin
                for (int i = 0; i < N_REPLICA; i++) begin
                        al_in[i] = '0;
                end
                for (int i = 0; i < 256; i++) begin
                        for (int b = 0; b < 16; b++) begin
                                lfsr        = lfsr_step(lfsr);
                                image[i][b] = lfsr[0];
                        end
                end
                err_mark = 0;
                tmo_mark = 0;
                cyc      = 0;
                while (!por_n && cyc < 50) begin
                        @(posedge clk);
                        cyc++;
                end
                if (!por_n) begin
                        $display("Timeout: power-on reset was never released");
                        timeouts++;
                end

                repeat (3) run_cycle(1'b0, '0, '0, 1'b0);
                end_test("reset state");

                bp_en = 1'b1;
                run_instrs(300, 3000);
                end_test("clean stream with back-pressure");

                run_cycle(1'b1, 32'h0000_0040, '0, 1'b0);
                run_instrs(40, 400);
                run_cycle(1'b1, 32'h0000_008a, '0, 1'b0);
                run_instrs(40, 400);
                end_test("branches");

                apply_reset();
                corrupt_req = 3'b010;
                wait_broken(1, 30);
                run_instrs(30, 300);
                end_test("copy 1 corrupted");

                apply_reset();
                run_cycle(1'b0, '0, 3'b100, 1'b0);
                wait_broken(2, 5);
                corrupt_req = 3'b010;
                cyc = 0;
                while (!corrupt[1] && cyc < 10) begin
                        run_cycle(1'b0, '0, '0, 1'b0);
                        cyc++;
                end
                if (!corrupt[1]) begin
                        $display("Timeout: corruption of copy 1 never started");
                        timeouts++;
                end
                run_instrs(2, 20);
                end_test("copy 2 forced broken, copy 1 corrupted");

                $display("Totals: %0d instructions taken, %0d errors, %0d timeouts",
                         taken, errors, timeouts);
                if (errors == 0 && timeouts == 0) begin
                        $display("Simulation passed");
                end else begin
                        $display("Simulation failed");
                end
                $finish;
        end

endmodule

// File: dv/tb_checker.sv
/*
 * Scoreboard for the voted aligner output.
 * Walks a halfword program image to predict instruction and PC pairs,
 * and models the voter flags and monitor scores from the corruption mask.
 * Samples on the falling edge, where inputs and outputs are settled.
 */
`timescale 1ns/1ps

module tb_checker #(
        parameter int unsigned INCREMENT       = 3,
        parameter int unsigned DECREMENT       = 1,
        parameter int unsigned BREAK_THRESHOLD = 9,
        parameter int unsigned COUNT_W         = 5
) (
        input  logic                 clk,
        input  logic                 rst_n_i,
        input  aligner_pkg::al_in_t  in0_i,
        input  logic [2:0]           set_broken_i,
        input  logic [2:0]           corrupt_i,
        input  aligner_pkg::al_out_t out_i,
        input  logic [2:0]           is_broken_i,
        input  logic                 det_i,
        input  logic                 corr_i,
        input  aligner_pkg::half_t   image_i [256],
        output int                   errors_o,
        output int                   taken_o
);
        import aligner_pkg::*;

        int          err_cnt = 0;
        int          taken_cnt = 0;
        int          score [3];
        logic [2:0]  exp_broken;
        logic [2:0]  exp_block;
        logic        exp_det;
        logic        exp_corr;
        logic [31:0] exp_pc;
        logic        after_rst = 1'b1;
        logic        from_branch = 1'b0;

        assign errors_o = err_cnt;
        assign taken_o  = taken_cnt;

        // Instruction that starts at byte address pc in the image
        function automatic logic [31:0] ref_instr(input logic [31:0] pc);
                logic [15:0] p0;
                logic [15:0] p1;
                p0 = image_i[pc[8:1]];
                p1 = image_i[pc[8:1] + 8'd1];
                if (p0[1:0] != 2'b11) begin
                        return {16'h0000, p0};
                end
                return {p1, p0};
        endfunction

        function automatic logic [31:0] ref_len(input logic [31:0] pc);
                logic [15:0] p0;
                p0 = image_i[pc[8:1]];
                return (p0[1:0] != 2'b11) ? 32'd2 : 32'd4;
        endfunction

        task automatic mismatch(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
                $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
                err_cnt++;
        endtask

        always @(negedge clk) begin
                int         nb;
                logic [2:0] healthy;
                logic [2:0] next_broken;
                logic       exp_ready;
                if (!rst_n_i) begin
                        exp_broken  = '0;
                        exp_pc      = '0;
                        after_rst   = 1'b1;
                        from_branch = 1'b0;
                        for (int k = 0; k < 3; k++) begin
                                score[k] = 0;
                        end
                end else begin
                        if (after_rst) begin
                                if (out_i.instr_valid !== 1'b0) begin
                                        mismatch("instr_valid after reset", 32'(out_i.instr_valid), 0);
                                end
                                after_rst = 1'b0;
                        end

                        ////////////////////////////////////////
                        // Voter flags
                        ////////////////////////////////////////
                        nb      = $countones(exp_broken);
                        healthy = ~exp_broken;
                        if (nb == 0) begin
                                exp_det   = |corrupt_i;
                                exp_corr  = exp_det;
                                exp_block = corrupt_i;
                        end else if (nb == 1) begin
                                exp_det   = |(corrupt_i & healthy);
                                exp_corr  = 1'b0;
                                exp_block = exp_det ? healthy : 3'b000;
                        end else begin
                                exp_det   = 1'b0;
                                exp_corr  = 1'b0;
                                exp_block = 3'b000;
                        end
                        if (det_i !== exp_det) begin
                                mismatch("err_detected", 32'(det_i), 32'(exp_det));
                        end
                        if (corr_i !== exp_corr) begin
                                mismatch("err_corrected", 32'(corr_i), 32'(exp_corr));
                        end
                        if (is_broken_i !== exp_broken) begin
                                mismatch("is_broken", 32'(is_broken_i), 32'(exp_broken));
                        end

                        ////////////////////////////////////////
                        // Instruction stream
                        ////////////////////////////////////////

                        // Ready is low only while a whole compressed parcel is held
                        exp_ready = !(exp_pc[1] && !from_branch &&
                                      image_i[exp_pc[8:1]][1:0] != 2'b11);
                        if (out_i.ready !== exp_ready) begin
                                mismatch("ready", 32'(out_i.ready), 32'(exp_ready));
                        end

                        if (in0_i.branch) begin
                                if (out_i.instr_valid !== 1'b0) begin
                                        mismatch("instr_valid in branch cycle", 1, 0);
                                end
                                exp_pc      = in0_i.branch_addr;
                                from_branch = 1'b1;
                        end else if (out_i.instr_valid && in0_i.if_valid) begin
                                if (out_i.pc !== exp_pc) begin
                                        mismatch("pc", out_i.pc, exp_pc);
                                end
                                if (out_i.instr !== ref_instr(exp_pc)) begin
                                        mismatch("instr", out_i.instr, ref_instr(exp_pc));
                                end
                                exp_pc      = exp_pc + ref_len(exp_pc);
                                from_branch = 1'b0;
                                taken_cnt++;
                        end

                        // Monitor model, mirrors the coming rising edge
                        next_broken = exp_broken | set_broken_i;
                        for (int k = 0; k < 3; k++) begin
                                if (score[k] >= int'(BREAK_THRESHOLD)) begin
                                        next_broken[k] = 1'b1;
                                end
                                if (exp_block[k]) begin
                                        score[k] = score[k] + int'(INCREMENT);
                                        if (score[k] > (2 ** COUNT_W) - 1) begin
                                                score[k] = (2 ** COUNT_W) - 1;
                                        end
                                end else if (score[k] > int'(DECREMENT)) begin
                                        score[k] = score[k] - int'(DECREMENT);
                                end else begin
                                        score[k] = 0;
                                end
                        end
                        exp_broken = next_broken;
                end
        end

endmodule

// File: dv/tb_clk_gen.sv
/*
 * Free-running testbench clock and power-on reset.
 * Reset is released 2 ns after the last rising edge of the reset window.
 */
`timescale 1ns/1ps

module tb_clk_gen #(
        parameter int unsigned PERIOD_NS    = 20,
        parameter int unsigned RESET_CYCLES = 10
) (
        output logic clk_o,
        output logic rst_n_o
);
        initial begin
                clk_o = 1'b0;
                forever #(PERIOD_NS / 2) clk_o = ~clk_o;
        end

        initial begin
                rst_n_o = 1'b0;
                repeat (RESET_CYCLES) @(posedge clk_o);
                #2;
                rst_n_o = 1'b1;
        end

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
        -f sources.f \
        --top-module tb_aligner_tmr \
        --Mdir build -o sim_aligner_tmr

./build/sim_aligner_tmr | tee sim.log

if grep -q "Simulation failed" sim.log; then
        exit 1
fi
exit 0

// File: sources.f
verilog/aligner_pkg.sv
verilog/fetch_aligner.sv
verilog/tmr_voter.sv
verilog/breakage_monitor.sv
verilog/aligner_tmr.sv
dv/tb_clk_gen.sv
dv/tb_checker.sv
dv/aligner_tmr_sva.sv
dv/tb_aligner_tmr.sv

// File: verilog/aligner_pkg.sv
/*
 * Shared types for the triplicated fetch aligner.
 * Fetch words are 32 bits, little endian in halfwords (lower parcel first).
 * N_REPLICA is fixed at 3 because the voter only handles three copies.
 */
package aligner_pkg;

        localparam int N_REPLICA = 3;

        ////////////////////////////////////////
        // Instruction words
        ////////////////////////////////////////

        typedef logic [15:0] half_t;
        typedef logic [31:0] word_t;

        typedef struct packed {
                half_t hi;
                half_t lo;
        } parcels_t;

        // One fetch word, seen as a full instruction or as two parcels
        typedef union packed {
                word_t    word;
                parcels_t half;
        } instr_u;

        ////////////////////////////////////////
        // Per-copy bundles
        ////////////////////////////////////////

        typedef struct packed {
                logic        fetch_valid;
                instr_u      fetch_rdata;
                logic        if_valid;
                logic        branch;
                logic [31:0] branch_addr;
        } al_in_t;

        typedef struct packed {
                logic        ready;
                logic        instr_valid;
                word_t       instr;
                logic [31:0] pc;
        } al_out_t;

        typedef enum logic [1:0] {
                ALIGNED,
                MISALIGNED32,
                MISALIGNED16,
                BRANCH_MISALIGNED
        } al_state_e;

        // RVC parcels never have both low bits set
        function automatic logic is_compressed(input half_t parcel);
                return parcel[1:0] != 2'b11;
        endfunction

endpackage

// File: verilog/aligner_tmr.sv
/*
 * Triplicated fetch aligner with a single voted output bundle.
 * Each copy has its own input bundle; copy k sees only al_in_i[k].
 * Outputs and error flags are combinational from inputs and state.
 */
`timescale 1ns/1ps

module aligner_tmr #(
        parameter int unsigned INCREMENT       = 3,
        parameter int unsigned DECREMENT       = 1,
        parameter int unsigned BREAK_THRESHOLD = 9,
        parameter int unsigned COUNT_W         = 5
) (
        input  logic                              clk,
        input  logic                              rst_n_i,
        input  aligner_pkg::al_in_t               al_in_i [aligner_pkg::N_REPLICA],
        input  logic [aligner_pkg::N_REPLICA-1:0] set_broken_i,
        output aligner_pkg::al_out_t              al_out_o,
        output logic [aligner_pkg::N_REPLICA-1:0] is_broken_o,
        output logic                              err_detected_o,
        output logic                              err_corrected_o
);
        import aligner_pkg::*;

        al_out_t              rep_out [N_REPLICA];
        logic [N_REPLICA-1:0] block_err;

        ////////////////////////////////////////
        // Replicas and their monitors
        ////////////////////////////////////////

        for (genvar g = 0; g < N_REPLICA; g++) begin : g_replica
                fetch_aligner i_aligner (
                        .clk     (clk),
                        .rst_n_i (rst_n_i),
                        .al_i    (al_in_i[g]),
                        .al_o    (rep_out[g])
                );

                breakage_monitor #(
                        .INCREMENT       (INCREMENT),
                        .DECREMENT       (DECREMENT),
                        .BREAK_THRESHOLD (BREAK_THRESHOLD),
                        .COUNT_W         (COUNT_W)
                ) i_monitor (
                        .clk            (clk),
                        .rst_n_i        (rst_n_i),
                        .err_detected_i (block_err[g]),
                        .set_broken_i   (set_broken_i[g]),
                        .is_broken_o    (is_broken_o[g])
                );
        end

        ////////////////////////////////////////
        // Voting
        ////////////////////////////////////////

        // Broken flags loop back so the voter skips retired copies
        tmr_voter i_voter (
                .vote_i          (rep_out),
                .broken_i        (is_broken_o),
                .voted_o         (al_out_o),
                .block_err_o     (block_err),
                .err_detected_o  (err_detected_o),
                .err_corrected_o (err_corrected_o)
        );

endmodule

// File: verilog/breakage_monitor.sv
/*
 * Saturating error score of one copy with a sticky broken flag.
 * The flag rises one edge after the score reaches the threshold,
 * or one edge after set_broken_i, and clears only on reset.
 */
`timescale 1ns/1ps

module breakage_monitor #(
        parameter int unsigned INCREMENT       = 3,
        parameter int unsigned DECREMENT       = 1,
        parameter int unsigned BREAK_THRESHOLD = 9,
        parameter int unsigned COUNT_W         = 5
) (
        input  logic clk,
        input  logic rst_n_i,
        input  logic err_detected_i,
        input  logic set_broken_i,
        output logic is_broken_o
);
        localparam logic [COUNT_W:0] INC_X = (COUNT_W + 1)'(INCREMENT);
        localparam logic [COUNT_W:0] MAX_X = {1'b0, {COUNT_W{1'b1}}};

        logic [COUNT_W-1:0] count_q, count_d;
        logic [COUNT_W:0]   sum;

        assign sum = {1'b0, count_q} + INC_X;

        always_comb begin
                if (err_detected_i) begin
                        count_d = (sum > MAX_X) ? MAX_X[COUNT_W-1:0] : sum[COUNT_W-1:0];
                end else if (count_q < COUNT_W'(DECREMENT)) begin
                        count_d = '0;
                end else begin
                        count_d = count_q - COUNT_W'(DECREMENT);
                end
        end

        always_ff @(posedge clk) begin
                if (!rst_n_i) begin
                        count_q     <= '0;
                        is_broken_o <= 1'b0;
                end else begin
                        count_q     <= count_d;
                        is_broken_o <= is_broken_o | set_broken_i |
                                       (count_q >= COUNT_W'(BREAK_THRESHOLD));
                end
        end

endmodule

// File: verilog/fetch_aligner.sv
/*
 * Splits 32-bit fetch words into 16-bit and 32-bit instructions with their PC.
 * Fetch words must come from word-aligned addresses following the PC.
 * Nothing advances while if_valid is low, except the silent parcel hold
 * after a branch to a misaligned target.
 */
`timescale 1ns/1ps

module fetch_aligner (
        input  logic                 clk,
        input  logic                 rst_n_i,
        input  aligner_pkg::al_in_t  al_i,
        output aligner_pkg::al_out_t al_o
);
        import aligner_pkg::*;

        al_state_e   state_q, state_d;
        logic [31:0] pc_q, pc_d;
        half_t       held_q, held_d;
        half_t       lo_h, hi_h;
        logic        take;

        assign lo_h = al_i.fetch_rdata.half.lo;
        assign hi_h = al_i.fetch_rdata.half.hi;

        // Instruction leaves toward the decoder
        assign take = al_o.instr_valid & al_i.if_valid;

        ////////////////////////////////////////
        // Output decode
        ////////////////////////////////////////

        always_comb begin
                al_o.ready       = 1'b1;
                al_o.instr_valid = 1'b0;
                al_o.instr       = al_i.fetch_rdata.word;
                al_o.pc          = pc_q;
                unique case (state_q)
                        ALIGNED: begin
                                al_o.instr_valid = al_i.fetch_valid;
                                if (is_compressed(lo_h)) begin
                                        al_o.instr = {16'h0000, lo_h};
                                end
                        end
                        MISALIGNED32: begin
                                // Upper half of the instruction arrives in the new word
                                al_o.instr_valid = al_i.fetch_valid;
                                al_o.instr       = {lo_h, held_q};
                        end
                        MISALIGNED16: begin
                                al_o.ready       = 1'b0;
                                al_o.instr_valid = 1'b1;
                                al_o.instr       = {16'h0000, held_q};
                        end
                        BRANCH_MISALIGNED: begin
                                al_o.instr_valid = al_i.fetch_valid & is_compressed(hi_h);
                                al_o.instr       = {16'h0000, hi_h};
                        end
                        default: ;
                endcase
                if (al_i.branch) begin
                        al_o.instr_valid = 1'b0;
                end
        end

        ////////////////////////////////////////
        // Next state
        ////////////////////////////////////////

        always_comb begin
                state_d = state_q;
                pc_d    = pc_q;
                held_d  = held_q;
                if (al_i.branch) begin
                        pc_d    = al_i.branch_addr;
                        state_d = al_i.branch_addr[1] ? BRANCH_MISALIGNED : ALIGNED;
                end else begin
                        unique case (state_q)
                                ALIGNED: begin
                                        if (take && is_compressed(lo_h)) begin
                                                pc_d    = pc_q + 32'd2;
                                                held_d  = hi_h;
                                                state_d = is_compressed(hi_h) ? MISALIGNED16
                                                                              : MISALIGNED32;
                                        end else if (take) begin
                                                pc_d = pc_q + 32'd4;
                                        end
                                end
                                MISALIGNED32: begin
                                        if (take) begin
                                                pc_d    = pc_q + 32'd4;
                                                held_d  = hi_h;
                                                state_d = is_compressed(hi_h) ? MISALIGNED16
                                                                              : MISALIGNED32;
                                        end
                                end
                                MISALIGNED16: begin
                                        if (take) begin
                                                pc_d    = pc_q + 32'd2;
                                                state_d = ALIGNED;
                                        end
                                end
                                BRANCH_MISALIGNED: begin
                                        if (take) begin
                                                pc_d    = pc_q + 32'd2;
                                                state_d = ALIGNED;
                                        end else if (al_i.fetch_valid && !is_compressed(hi_h)) begin
                                                // Start of a straddling 32-bit instruction, PC stays
                                                held_d  = hi_h;
                                                state_d = MISALIGNED32;
                                        end
                                end
                                default: state_d = ALIGNED;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (!rst_n_i) begin
                        state_q <= ALIGNED;
                        pc_q    <= '0;
                end else begin
                        state_q <= state_d;
                        pc_q    <= pc_d;
                end
        end

        always_ff @(posedge clk) begin
                held_q <= held_d;
        end

endmodule

// File: verilog/tmr_voter.sv
/*
 * Purely combinational voter over the three aligner output bundles.
 * With no broken copy it takes the bitwise majority; otherwise it passes
 * the lowest healthy copy, or copy 0 when all are broken.
 */
`timescale 1ns/1ps

module tmr_voter (
        input  aligner_pkg::al_out_t              vote_i [aligner_pkg::N_REPLICA],
        input  logic [aligner_pkg::N_REPLICA-1:0] broken_i,
        output aligner_pkg::al_out_t              voted_o,
        output logic [aligner_pkg::N_REPLICA-1:0] block_err_o,
        output logic                              err_detected_o,
        output logic                              err_corrected_o
);
        import aligner_pkg::*;

        localparam int IDX_W = $clog2(N_REPLICA);

        al_out_t              maj;
        logic [N_REPLICA-1:0] healthy;
        logic [N_REPLICA-1:0] differs;
        logic [IDX_W-1:0]     first_idx;

        assign maj = (vote_i[0] & vote_i[1]) | (vote_i[1] & vote_i[2]) |
                     (vote_i[0] & vote_i[2]);

        assign healthy = ~broken_i;

        // Lowest healthy copy, 0 if none
        always_comb begin
                first_idx = '0;
                for (int k = N_REPLICA - 1; k >= 0; k--) begin
                        if (healthy[k]) begin
                                first_idx = IDX_W'(k);
                        end
                end
        end

        // Compare against majority, or against the first healthy copy
        always_comb begin
                for (int k = 0; k < N_REPLICA; k++) begin
                        if (broken_i == '0) begin
                                differs[k] = vote_i[k] != maj;
                        end else begin
                                differs[k] = healthy[k] && (vote_i[k] != vote_i[first_idx]);
                        end
                end
        end

        always_comb begin
                voted_o         = vote_i[first_idx];
                block_err_o     = '0;
                err_detected_o  = 1'b0;
                err_corrected_o = 1'b0;
                case ($countones(broken_i))
                        0: begin
                                voted_o         = maj;
                                block_err_o     = differs;
                                err_detected_o  = |differs;
                                err_corrected_o = |differs;
                        end
                        1: begin
                                // Two survivors, cannot tell which one is wrong
                                err_detected_o = |differs;
                                block_err_o    = (|differs) ? healthy : '0;
                        end
                        default: ;
                endcase
        end

endmodule
